//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= ncpu_issue_tb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- compile.f
source/ncpu_pkg.sv
source/fifo_fwft.sv
source/insn_decode.sv
source/alu_execute.sv
source/result_buffer.sv
source/ncpu_issue_top.sv
verif/tb_clock_gen.sv
verif/ncpu_issue_tb.sv

//--- source/alu_execute.sv
/*
 * alu_execute
 * register file and ALU, reads and writes the registers in one stage
 * and holds one result per accepted micro-op in its output register
 */
`timescale 1ns/1ps

module alu_execute import ncpu_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      uop_valid,
   input  uop_t      uop,
   output logic      exe_ready,
   output logic      res_valid,
   output result_t   res,
   input  logic      res_ready
);

   logic [xlen-1:0]  regs [nreg];
   logic [xlen-1:0]  src_a;
   logic [xlen-1:0]  src_b;
   logic [xlen-1:0]  alu_out;
   logic             accept;

   // the output register can take a new result when empty or draining
   assign exe_ready = ~res_valid | res_ready;
   assign accept    = uop_valid & exe_ready;

   // register 0 reads as zero, it is never written
   assign src_a = (uop.rs1 == '0) ? '0 : regs[uop.rs1];
   assign src_b = uop.use_imm ? uop.imm :
                  ((uop.rs2 == '0) ? '0 : regs[uop.rs2]);

   always_comb begin
      case (uop.op)
         op_add:  alu_out = src_a + src_b;
         op_sub:  alu_out = src_a - src_b;
         op_and:  alu_out = src_a & src_b;
         op_or:   alu_out = src_a | src_b;
         op_xor:  alu_out = src_a ^ src_b;
         op_sll:  alu_out = src_a << src_b[shamt_width-1:0];
         // signed compare, result is 0 or 1
         op_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(src_a) < $signed(src_b)};
         op_addi: alu_out = src_a + src_b;
         // lui takes the shifted immediate as is
         op_lui:  alu_out = src_b;
         // illegal opcodes produce zero
         default: alu_out = '0;
      endcase
   end

   // writeback on the acceptance edge so the next micro-op sees the value
   always_ff @(posedge clk) begin
      if (accept && !uop.illegal && uop.rd != '0)
         regs[uop.rd] <= alu_out;
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         res_valid <= 1'b0;
      else if (accept)
         res_valid <= 1'b1;
      else if (res_ready)
         res_valid <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         res.tag     <= uop.tag;
         res.rd      <= uop.rd;
         res.value   <= alu_out;
         res.illegal <= uop.illegal;
      end
   end

   // a stalled result is held until the result buffer takes it
   a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid && !res_ready |=> res_valid && $stable(res));

endmodule

//--- source/fifo_fwft.sv
/*
 * fifo_fwft
 * first-word-fall-through FIFO with flush, a head register for words
 * written into an empty FIFO and a bypass for same-slot write and read
 */
`timescale 1ns/1ps

module fifo_fwft #(
   parameter int DW = 8,
   parameter int DEPTH_WIDTH = 2
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            flush,
   input  logic            push,
   input  logic [DW-1:0]   din,
   output logic            ready,
   input  logic            pop,
   output logic [DW-1:0]   dout,
   output logic            valid
);

   // pointers carry one extra bit to tell full from empty
   logic [DEPTH_WIDTH:0]   w_ptr;
   logic [DEPTH_WIDTH:0]   r_ptr;
   logic [DEPTH_WIDTH:0]   r_ptr_nxt;
   logic [DW-1:0]          mem [1 << DEPTH_WIDTH];
   logic [DW-1:0]          rd_q;
   logic [DW-1:0]          head_q;
   logic [DW-1:0]          byp_q;
   logic                   head_vld;
   logic                   byp_sel;
   logic                   head_load;
   logic                   head_clr;
   logic                   same_slot;

   assign r_ptr_nxt = r_ptr + 1'b1;

   // full when the wrap bits differ and the address bits match
   assign ready = (w_ptr[DEPTH_WIDTH] == r_ptr[DEPTH_WIDTH]) ||
                  (w_ptr[DEPTH_WIDTH-1:0] != r_ptr[DEPTH_WIDTH-1:0]);
   assign valid = (w_ptr != r_ptr);

   // a word pushed into an empty FIFO is caught in the head register
   assign head_load = push & ~valid & ~head_vld;
   assign head_clr  = pop & head_vld;

   // the read of the next head would see the slot being written this cycle
   assign same_slot = push & pop &
                      (w_ptr[DEPTH_WIDTH-1:0] == r_ptr_nxt[DEPTH_WIDTH-1:0]);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         w_ptr <= '0;
         r_ptr <= '0;
      end else if (flush) begin
         w_ptr <= '0;
         r_ptr <= '0;
      end else begin
         if (push)
            w_ptr <= w_ptr + 1'b1;
         if (pop)
            r_ptr <= r_ptr_nxt;
      end
   end

   // head register state, flush drops whatever it holds
   always_ff @(posedge clk) begin
      if (!rst_n || flush)
         head_vld <= 1'b0;
      else if (head_load)
         head_vld <= 1'b1;
      else if (head_clr)
         head_vld <= 1'b0;
   end

   // bypass select lasts until the next pop replaces the head
   always_ff @(posedge clk) begin
      if (!rst_n)
         byp_sel <= 1'b0;
      else if (same_slot)
         byp_sel <= 1'b1;
      else if (pop)
         byp_sel <= 1'b0;
   end

   // storage and the registered read of the entry behind the head
   always_ff @(posedge clk) begin
      if (push)
         mem[w_ptr[DEPTH_WIDTH-1:0]] <= din;
      if (pop) begin
         rd_q  <= mem[r_ptr_nxt[DEPTH_WIDTH-1:0]];
         byp_q <= din;
      end
      if (head_load)
         head_q <= din;
   end

   assign dout = head_vld ? head_q : (byp_sel ? byp_q : rd_q);

   // the writer may only push into a full FIFO when a pop frees a slot
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      push && !ready |-> pop);

endmodule

//--- source/insn_decode.sv
/*
 * insn_decode
 * turns the FIFO head into a micro-op, picks the R or I view of the word
 * and extends the immediate, unknown opcodes are flagged illegal
 */
`timescale 1ns/1ps

module insn_decode import ncpu_pkg::*; (
   input  logic         pkt_valid,
   input  issue_pkt_t   pkt,
   output logic         uop_valid,
   output uop_t         uop
);

   opcode_e    opc;
   logic       is_rr;
   logic       is_ri;
   logic [15:0] imm16;

   // the opcode sits in the same bits in both views
   assign opc   = pkt.insn.r.opcode;
   assign imm16 = pkt.insn.i.imm16;

   // sort the opcode into its format class
   always_comb begin
      is_rr = 1'b0;
      is_ri = 1'b0;
      case (opc)
         op_add, op_sub, op_and, op_or, op_xor, op_sll, op_slt: is_rr = 1'b1;
         op_addi, op_lui: is_ri = 1'b1;
         default: ;
      endcase
   end

   always_comb begin
      uop.tag     = pkt.tag;
      uop.op      = opc;
      uop.rd      = pkt.insn.r.rd;
      uop.rs1     = pkt.insn.r.rs1;
      // the I view has no rs2 field because those bits are spare there
      uop.rs2     = is_rr ? pkt.insn.r.rs2 : '0;
      uop.use_imm = is_ri;
      uop.illegal = ~(is_rr | is_ri);
      // addi sign-extends and lui places the immediate in the upper half
      if (opc == op_lui)
         uop.imm = {imm16, {(xlen-16){1'b0}}};
      else if (opc == op_addi)
         uop.imm = {{(xlen-16){imm16[15]}}, imm16};
      else
         uop.imm = '0;
   end

   // decode adds no cycle so valid follows the FIFO head directly
   assign uop_valid = pkt_valid;

   // legal register-immediate codes are the ones with the top opcode bit set
   always_comb begin
      if (pkt_valid) begin
         a_imm_class: assert (uop.use_imm == (pkt.insn.i.opcode[3] && !uop.illegal));
      end
   end

endmodule

//--- source/ncpu_issue_top.sv
/*
 * ncpu_issue_top
 * in-order issue slice, FIFO then decode then execute then result buffer
 */
`timescale 1ns/1ps

module ncpu_issue_top import ncpu_pkg::*; (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         flush,
   input  logic         in_valid,
   output logic         in_ready,
   input  issue_pkt_t   in_pkt,
   output logic         out_valid,
   output result_t      out_res,
   input  logic         out_ready
);

   logic       push;
   logic       pop;
   logic       fifo_valid;
   issue_pkt_t fifo_pkt;
   logic       uop_valid;
   uop_t       uop;
   logic       exe_ready;
   logic       res_valid;
   result_t    res;
   logic       res_ready;

   // handshakes on both sides of the FIFO
   assign push = in_valid & in_ready;
   assign pop  = uop_valid & exe_ready;

   fifo_fwft #(
      .DW          ($bits(issue_pkt_t)),
      .DEPTH_WIDTH (fifo_depth_width)
   ) u_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .flush (flush),
      .push  (push),
      .din   (in_pkt),
      .ready (in_ready),
      .pop   (pop),
      .dout  (fifo_pkt),
      .valid (fifo_valid)
   );

   insn_decode u_decode (
      .pkt_valid (fifo_valid),
      .pkt       (fifo_pkt),
      .uop_valid (uop_valid),
      .uop       (uop)
   );

   alu_execute u_execute (
      .clk       (clk),
      .rst_n     (rst_n),
      .uop_valid (uop_valid),
      .uop       (uop),
      .exe_ready (exe_ready),
      .res_valid (res_valid),
      .res       (res),
      .res_ready (res_ready)
   );

   result_buffer u_result (
      .clk       (clk),
      .rst_n     (rst_n),
      .res_valid (res_valid),
      .res       (res),
      .res_ready (res_ready),
      .out_valid (out_valid),
      .out_res   (out_res),
      .out_ready (out_ready)
   );

endmodule

//--- source/ncpu_pkg.sv
/*
 * ncpu issue slice package
 * shared sizes, opcode encoding, the two instruction word views and the
 * records that travel between the issue stages
 */
package ncpu_pkg;

   // register data width and register file indexing
   localparam int xlen = 32;
   localparam int nreg_width = 3;
   localparam int nreg = 1 << nreg_width;
   // shift amount is taken from the low bits of the second operand
   localparam int shamt_width = $clog2(xlen);

   // every instruction carries a tag so results can be matched in order
   localparam int tag_width = 8;

   // the issue FIFO holds four packets
   localparam int fifo_depth_width = 2;

   // codes 7 and 10 to 15 are not assigned and decode as illegal
   typedef enum logic [3:0] {
      op_add  = 4'h0,
      op_sub  = 4'h1,
      op_and  = 4'h2,
      op_or   = 4'h3,
      op_xor  = 4'h4,
      op_sll  = 4'h5,
      op_slt  = 4'h6,
      op_addi = 4'h8,
      op_lui  = 4'h9
   } opcode_e;

   // register-register view of an instruction word
   typedef struct packed {
      opcode_e                opcode;
      logic [nreg_width-1:0]  rd;
      logic [nreg_width-1:0]  rs1;
      logic [nreg_width-1:0]  rs2;
      logic [18:0]            spare;
   } insn_r_t;

   // register-immediate view, opcode and register fields line up with the R view
   typedef struct packed {
      opcode_e                opcode;
      logic [nreg_width-1:0]  rd;
      logic [nreg_width-1:0]  rs1;
      logic [5:0]             spare;
      logic [15:0]            imm16;
   } insn_i_t;

   // one 32-bit word seen either way, the opcode picks the view
   typedef union packed {
      insn_r_t r;
      insn_i_t i;
   } insn_word_u;

   // what the issue FIFO stores, 40 bits
   typedef struct packed {
      logic [tag_width-1:0]   tag;
      insn_word_u             insn;
   } issue_pkt_t;

   // decoded micro-op handed from decode to execute
   typedef struct packed {
      logic [tag_width-1:0]   tag;
      opcode_e                op;
      logic [nreg_width-1:0]  rd;
      logic [nreg_width-1:0]  rs1;
      logic [nreg_width-1:0]  rs2;
      logic                   use_imm;
      logic [xlen-1:0]        imm;
      logic                   illegal;
   } uop_t;

   // one result per executed instruction
   typedef struct packed {
      logic [tag_width-1:0]   tag;
      logic [nreg_width-1:0]  rd;
      logic [xlen-1:0]        value;
      logic                   illegal;
   } result_t;

endpackage

//--- source/result_buffer.sv
/*
 * result_buffer
 * two-entry skid buffer, keeps results in order and gives the execute
 * stage a registered ready with no path from out_ready
 */
`timescale 1ns/1ps

module result_buffer import ncpu_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      res_valid,
   input  result_t   res,
   output logic      res_ready,
   output logic      out_valid,
   output result_t   out_res,
   input  logic      out_ready
);

   result_t skid_res;
   logic    acc_in;
   logic    acc_out;
   logic    load_main;
   logic    load_skid;
   logic    drain_skid;

   assign acc_in  = res_valid & res_ready;
   assign acc_out = out_valid & out_ready;

   // incoming result goes to the main entry if it is free or leaving
   assign load_main  = acc_in & (~out_valid | acc_out);
   assign load_skid  = acc_in & out_valid & ~acc_out;
   // res_ready low means the skid entry is occupied
   assign drain_skid = ~res_ready & acc_out;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         res_ready <= 1'b1;
      end else begin
         if (load_main)
            out_valid <= 1'b1;
         else if (acc_out && res_ready)
            out_valid <= 1'b0;
         if (load_skid)
            res_ready <= 1'b0;
         else if (drain_skid)
            res_ready <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (drain_skid)
         out_res <= skid_res;
      else if (load_main)
         out_res <= res;
      if (load_skid)
         skid_res <= res;
   end

   a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_res));

endmodule

//--- verif/ncpu_issue_tb.sv
/*
 * ncpu_issue_tb
 * random tagged instruction stream into the issue slice, a register model
 * checks every result in tag order under back-pressure, flush and bursts
 */
`timescale 1ns/1ps

module ncpu_issue_tb import ncpu_pkg::*; ();

   // packets per test, the cycle limit allows 20 cycles for each of them
   localparam int n_pkts = 9 + 300 + 67 + 221 + 51 + 120;
   localparam int cycle_limit = n_pkts * 20 + 200;
   // FIFO entries plus the execute register plus the two result entries
   localparam int pipe_slots = 7;

   // a packet waiting for its result, flushed marks it as droppable
   typedef struct packed {
      logic       flushed;
      issue_pkt_t pkt;
   } pending_t;

   localparam logic [3:0] legal_ops [9] = '{op_add, op_sub, op_and, op_or, op_xor,
                                            op_sll, op_slt, op_addi, op_lui};
   localparam logic [3:0] illegal_ops [7] = '{4'h7, 4'ha, 4'hb, 4'hc, 4'hd, 4'he, 4'hf};

   logic       clk;
   logic       rst_n;
   logic       flush;
   logic       in_valid;
   logic       in_ready;
   issue_pkt_t in_pkt;
   logic       out_valid;
   result_t    out_res;
   logic       out_ready;

   integer               seed;
   int                   ready_mode;
   int                   cycle_count = 0;
   int                   errors = 0;
   int                   test_errors = 0;
   int                   tests_run = 0;
   int                   tests_bad = 0;
   int                   total_results = 0;
   int                   test_results = 0;
   int                   test_accepted = 0;
   int                   test_skipped = 0;
   int                   illegal_seen = 0;
   int                   test_num;
   string                test_name;
   logic [tag_width-1:0] next_tag;
   logic [xlen-1:0]      model_regs [nreg];
   pending_t             pending_q [$];

   tb_clock_gen clock_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   ncpu_issue_top UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_pkt    (in_pkt),
      .out_valid (out_valid),
      .out_res   (out_res),
      .out_ready (out_ready)
   );

   // the run is stopped once it has gone far past its expected length
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         $display("timeout after %0d cycles with %0d packets still waiting for results",
                  cycle_limit, pending_q.size());
         $display("tests failed");
         $finish;
      end
   end

   function automatic int unsigned rand_below(int unsigned n);
      logic [31:0] r;
      r = $random(seed);
      return r % n;
   endfunction

   // random word with a chosen opcode, spare bits stay random on purpose
   function automatic issue_pkt_t make_insn(int unsigned illegal_pct);
      issue_pkt_t  p;
      logic [31:0] word;
      word = $random(seed);
      if (rand_below(100) < illegal_pct)
         word[31:28] = illegal_ops[3'(rand_below(7))];
      else
         word[31:28] = legal_ops[4'(rand_below(9))];
      p.tag  = next_tag;
      p.insn = word;
      next_tag++;
      return p;
   endfunction

   // R fields and imm16 do not overlap, so one builder serves both formats
   function automatic issue_pkt_t build_insn(opcode_e op, logic [nreg_width-1:0] rd,
                                             logic [nreg_width-1:0] rs1,
                                             logic [nreg_width-1:0] rs2, logic [15:0] imm);
      issue_pkt_t p;
      p              = '0;
      p.tag          = next_tag;
      p.insn.r.opcode = op;
      p.insn.r.rd    = rd;
      p.insn.r.rs1   = rs1;
      p.insn.r.rs2   = rs2;
      p.insn.i.imm16 = imm;
      next_tag++;
      return p;
   endfunction

   // reference behavior of one instruction, updates the model registers
   function automatic result_t model_exec(issue_pkt_t p);
      logic [xlen-1:0]        a;
      logic [xlen-1:0]        b;
      logic [xlen-1:0]        v;
      logic signed [xlen-1:0] simm;
      logic                   legal;
      a     = model_regs[p.insn.r.rs1];
      b     = model_regs[p.insn.r.rs2];
      simm  = 32'(signed'(p.insn.i.imm16));
      legal = 1'b1;
      case (p.insn.r.opcode)
         op_add:  v = a + b;
         op_sub:  v = a - b;
         op_and:  v = a & b;
         op_or:   v = a | b;
         op_xor:  v = a ^ b;
         op_sll:  v = a << b[shamt_width-1:0];
         op_slt:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         op_addi: v = a + simm;
         op_lui:  v = {p.insn.i.imm16, 16'h0000};
         default: begin
            v     = '0;
            legal = 1'b0;
         end
      endcase
      // register 0 stays zero in the model as well
      if (legal && p.insn.r.rd != '0)
         model_regs[p.insn.r.rd] = v;
      return '{tag: p.tag, rd: p.insn.r.rd, value: v, illegal: !legal};
   endfunction

   task automatic note_error();
      errors++;
      test_errors++;
   endtask

   task automatic check_result(result_t got, result_t exp);
      if (got.tag !== exp.tag) begin
         $display("error at %t: out_res.tag got %h expected %h", $time, got.tag, exp.tag);
         note_error();
      end
      if (got.rd !== exp.rd) begin
         $display("error at %t: out_res.rd got %h expected %h", $time, got.rd, exp.rd);
         note_error();
      end
      if (got.value !== exp.value) begin
         $display("error at %t: out_res.value got %h expected %h", $time, got.value,
                  exp.value);
         note_error();
      end
      if (got.illegal !== exp.illegal) begin
         $display("error at %t: out_res.illegal got %b expected %b", $time, got.illegal,
                  exp.illegal);
         note_error();
      end
   endtask

   task automatic check_count(string what, int got, int exp);
      if (got != exp) begin
         $display("error at %t: %s got %0d expected %0d", $time, what, got, exp);
         note_error();
      end
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("error at %t: %s got %b expected %b", $time, name, got, exp);
         note_error();
      end
   endtask

   // 0 holds out_ready low, 1 high, 2 high 30 percent, 3 high 50 percent
   task automatic apply_ready();
      case (ready_mode)
         0:       out_ready = 1'b0;
         2:       out_ready = (rand_below(10) < 3);
         3:       out_ready = (rand_below(2) == 0);
         default: out_ready = 1'b1;
      endcase
   endtask

   task automatic set_ready_mode(int mode);
      ready_mode = mode;
      apply_ready();
   endtask

   // every drive happens 1 ns after the rising edge
   task automatic step_cycle();
      @(posedge clk);
      #1;
      apply_ready();
   endtask

   // the handshake is judged at the falling edge, where all inputs are settled
   task automatic send_pkt(issue_pkt_t p);
      logic taken;
      taken    = 1'b0;
      in_pkt   = p;
      in_valid = 1'b1;
      while (!taken) begin
         @(negedge clk);
         if (in_ready) begin
            taken = 1'b1;
            pending_q.push_back('{flushed: 1'b0, pkt: p});
            test_accepted++;
         end
         step_cycle();
      end
      in_valid = 1'b0;
   endtask

   // one flush cycle with nothing pushed, all waiting packets become droppable
   task automatic flush_fifo();
      in_valid = 1'b0;
      flush    = 1'b1;
      @(negedge clk);
      foreach (pending_q[k])
         pending_q[k].flushed = 1'b1;
      step_cycle();
      flush = 1'b0;
   endtask

   // keeps pushing with out_ready low so the whole slice backs up
   task automatic push_into_stall(int cycles, output logic saw_full);
      issue_pkt_t p;
      saw_full = 1'b0;
      set_ready_mode(0);
      p        = make_insn(0);
      in_pkt   = p;
      in_valid = 1'b1;
      repeat (cycles) begin
         @(negedge clk);
         if (in_ready) begin
            pending_q.push_back('{flushed: 1'b0, pkt: p});
            test_accepted++;
            p = make_insn(0);
         end else begin
            saw_full = 1'b1;
         end
         step_cycle();
         in_pkt = p;
      end
      in_valid = 1'b0;
      set_ready_mode(2);
      send_pkt(p);
   endtask

   // results at or before a flush may skip only packets that were flushed
   task automatic take_result(result_t got);
      result_t  exp;
      pending_t head;
      total_results++;
      test_results++;
      if (got.illegal)
         illegal_seen++;
      while (pending_q.size() > 0 && pending_q[0].pkt.tag != got.tag) begin
         head = pending_q.pop_front();
         if (head.flushed) begin
            test_skipped++;
         end else begin
            $display("packet with tag %0d was lost before result tag %0d", head.pkt.tag,
                     got.tag);
            note_error();
         end
      end
      if (pending_q.size() == 0) begin
         $display("result with tag %0d matches no accepted packet", got.tag);
         note_error();
      end else begin
         head = pending_q.pop_front();
         exp  = model_exec(head.pkt);
         check_result(got, exp);
      end
   endtask

   always @(negedge clk) begin
      if (rst_n === 1'b1 && out_valid === 1'b1 && out_ready === 1'b1)
         take_result(out_res);
   end

   // waits for the queue to empty, a quiet pipeline ends the wait
   task automatic drain();
      int idle;
      int last;
      int missing;
      set_ready_mode(1);
      idle = 0;
      last = total_results;
      while (pending_q.size() > 0) begin
         step_cycle();
         if (total_results != last) begin
            idle = 0;
            last = total_results;
         end else begin
            idle++;
         end
         if (idle >= 16) begin
            missing = 0;
            foreach (pending_q[k])
               if (!pending_q[k].flushed)
                  missing++;
            if (missing > 0) begin
               $display("%0d packets never produced a result", missing);
               note_error();
            end
            test_skipped += pending_q.size() - missing;
            pending_q.delete();
         end
      end
      repeat (4) step_cycle();
   endtask

   task automatic start_test(int num, string name);
      test_num      = num;
      test_name     = name;
      test_errors   = 0;
      test_results  = 0;
      test_accepted = 0;
      test_skipped  = 0;
      illegal_seen  = 0;
   endtask

   task automatic finish_test();
      drain();
      check_count("result count", test_results, test_accepted - test_skipped);
      tests_run++;
      if (test_errors > 0)
         tests_bad++;
      $display("test %0d %s: %0d accepted, %0d results, %0d flushed, %0d errors, %s",
               test_num, test_name, test_accepted, test_results, test_skipped, test_errors,
               (test_errors == 0) ? "pass" : "fail");
   endtask

   // add into r0 returns the register value without writing anything
   task automatic read_all_regs();
      logic [nreg_width-1:0] r;
      for (int k = 1; k < nreg; k++) begin
         r = k[nreg_width-1:0];
         send_pkt(build_insn(op_add, '0, r, '0, '0));
      end
   endtask

   initial begin
      logic                  saw_full;
      int                    n;
      logic [nreg_width-1:0] r;
      $timeformat(-9, 0, " ns", 1);
      seed       = 32'h9a0a;
      next_tag   = '0;
      flush      = 1'b0;
      in_valid   = 1'b0;
      in_pkt     = '0;
      out_ready  = 1'b1;
      ready_mode = 1;
      foreach (model_regs[k])
         model_regs[k] = '0;
      wait (rst_n === 1'b1);

      start_test(1, "reset state and lui then addi");
      check_flag("out_valid", out_valid, 1'b0);
      check_flag("in_ready", in_ready, 1'b1);
      set_ready_mode(1);
      // the register file has no reset, so every register gets a value first
      for (int k = 1; k < nreg; k++) begin
         r = k[nreg_width-1:0];
         send_pkt(build_insn(op_addi, r, '0, '0, 16'(rand_below(65536))));
      end
      send_pkt(build_insn(op_lui, 3'd3, '0, '0, 16'h8765));
      send_pkt(build_insn(op_addi, 3'd3, 3'd3, '0, 16'hfff0));
      finish_test();

      start_test(2, "random legal stream");
      set_ready_mode(1);
      repeat (300) send_pkt(make_insn(0));
      finish_test();

      start_test(3, "illegal opcodes");
      repeat (60) send_pkt(make_insn(35));
      read_all_regs();
      drain();
      check_flag("illegal results seen", illegal_seen > 0, 1'b1);
      finish_test();

      start_test(4, "random back-pressure");
      set_ready_mode(2);
      repeat (200) send_pkt(make_insn(10));
      push_into_stall(20, saw_full);
      check_flag("in_ready fell during stall", saw_full, 1'b1);
      finish_test();

      start_test(5, "flush with queued packets");
      repeat (4) begin
         set_ready_mode(0);
         repeat (6) send_pkt(make_insn(0));
         flush_fifo();
         set_ready_mode(3);
         repeat (5) send_pkt(make_insn(0));
         drain();
      end
      // flushed packets must not have touched the register file
      read_all_regs();
      drain();
      check_flag("flush dropped packets", test_skipped > 0, 1'b1);
      finish_test();

      start_test(6, "bursts near empty and near full");
      repeat (20) begin
         n = 1 + int'(rand_below(6));
         if (rand_below(2) == 0) begin
            // out_ready low, so the burst must fit in the free slots
            set_ready_mode(0);
            if (n > pipe_slots - pending_q.size())
               n = pipe_slots - pending_q.size();
         end else begin
            set_ready_mode(1);
         end
         repeat (n) send_pkt(make_insn(0));
         set_ready_mode((rand_below(2) == 0) ? 1 : 3);
         repeat (rand_below(4)) step_cycle();
      end
      finish_test();

      $display("summary: %0d tests run, %0d with errors, %0d results checked, %0d errors",
               tests_run, tests_bad, total_results, errors);
      if (errors == 0 && tests_bad == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

//--- verif/tb_clock_gen.sv
/*
 * tb_clock_gen
 * free-running 8 ns clock and a synchronous active-low reset that is
 * held over the first two rising edges
 */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   // half period of 4 ns
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // reset is released just after the second rising edge
   initial begin
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule
